/* common/chess_pkg.sv */
package chess_pkg;

   localparam int board_rows    = 8;
   localparam int board_cols    = 8;
   localparam int board_squares = board_rows * board_cols;
   localparam int piece_width   = 4;
   localparam int board_width   = board_squares * piece_width; // square 0 in the low nibble

   localparam logic       color_white = 1'b0;
   localparam logic       color_black = 1'b1;
   localparam logic [2:0] kind_empty  = 3'd0;
   localparam logic [2:0] kind_pawn   = 3'd1;

   localparam logic [piece_width-1:0] white_pawn = {color_white, kind_pawn};
   localparam logic [piece_width-1:0] black_pawn = {color_black, kind_pawn};

   typedef struct packed
   {
      logic       color; // bit 3
      logic [2:0] kind;
   } piece_fields_t;

   // one square, read as a whole code or as its fields
   typedef union packed
   {
      logic [piece_width-1:0] code;
      piece_fields_t          fields;
   } square_t;

endpackage

/* common/eval_pkg.sv */
package eval_pkg;

   localparam int eval_width   = 16;
   localparam int pipe_latency = 7; // board capture to evaluator output
   localparam int max_distance = 5; // doubled pawn lookahead
   localparam int count_width  = 4;

   // the sum stage adds one more cycle
   localparam logic [count_width-1:0] latency_load = count_width'(pipe_latency + 1);

   localparam logic [1:0] sm_idle = 2'd0;
   localparam logic [1:0] sm_busy = 2'd1;
   localparam logic [1:0] sm_done = 2'd2;

   localparam int term_isolated  = 0;
   localparam int term_doubled   = 1;
   localparam int term_connected = 2;
   localparam int term_backward  = 3;
   localparam int term_count     = 4;

   localparam logic signed [eval_width-1:0] isolated_mg [8] =
      '{-8, -10, -12, -14, -14, -12, -10, -8};
   localparam logic signed [eval_width-1:0] isolated_eg [8] =
      '{-12, -13, -14, -15, -15, -14, -13, -12};

   // column, then distance 1 to 5
   localparam logic signed [eval_width-1:0] doubled_mg [8][max_distance] =
      '{'{-10, -8, -6, -4, -2},
        '{-12, -9, -7, -5, -3},
        '{-13, -10, -8, -6, -3},
        '{-14, -11, -9, -6, -4},
        '{-14, -11, -9, -6, -4},
        '{-13, -10, -8, -6, -3},
        '{-12, -9, -7, -5, -3},
        '{-10, -8, -6, -4, -2}};
   localparam logic signed [eval_width-1:0] doubled_eg [8][max_distance] =
      '{'{-16, -13, -10, -7, -4},
        '{-18, -14, -11, -8, -5},
        '{-19, -15, -12, -9, -5},
        '{-20, -16, -13, -9, -6},
        '{-20, -16, -13, -9, -6},
        '{-19, -15, -12, -9, -5},
        '{-18, -14, -11, -8, -5},
        '{-16, -13, -10, -7, -4}};

   // row, then column; rows 0 and 7 never hold pawns
   localparam logic signed [eval_width-1:0] connected_mg [8][8] =
      '{'{0, 0, 0, 0, 0, 0, 0, 0},
        '{2, 3, 3, 4, 4, 3, 3, 2},
        '{3, 4, 5, 6, 6, 5, 4, 3},
        '{5, 6, 7, 9, 9, 7, 6, 5},
        '{8, 9, 11, 13, 13, 11, 9, 8},
        '{12, 14, 16, 19, 19, 16, 14, 12},
        '{20, 23, 26, 30, 30, 26, 23, 20},
        '{0, 0, 0, 0, 0, 0, 0, 0}};
   localparam logic signed [eval_width-1:0] connected_eg [8][8] =
      '{'{0, 0, 0, 0, 0, 0, 0, 0},
        '{3, 3, 4, 4, 4, 4, 3, 3},
        '{4, 5, 6, 7, 7, 6, 5, 4},
        '{7, 8, 9, 10, 10, 9, 8, 7},
        '{11, 12, 14, 16, 16, 14, 12, 11},
        '{17, 19, 21, 24, 24, 21, 19, 17},
        '{28, 31, 34, 38, 38, 34, 31, 28},
        '{0, 0, 0, 0, 0, 0, 0, 0}};

   localparam logic signed [eval_width-1:0] backward_mg [8] =
      '{-6, -8, -9, -10, -10, -9, -8, -6};
   localparam logic signed [eval_width-1:0] backward_eg [8] =
      '{-8, -9, -10, -11, -11, -10, -9, -8};

endpackage

/* evaluate_pawns/evaluate_pawns.sv */
`timescale 1ns/100ps

module evaluate_pawns
#(
   parameter bit white_pawns = 1'b1
)
(
   input  logic                                   clk,
   input  logic [chess_pkg::board_width-1:0]      board,
   output logic signed [eval_pkg::eval_width-1:0] eval_mg,
   output logic signed [eval_pkg::eval_width-1:0] eval_eg
);

   wire [chess_pkg::piece_width-1:0] pawn_code =
      white_pawns ? chess_pkg::white_pawn : chess_pkg::black_pawn;

   logic [chess_pkg::board_width-1:0]   board_t0;
   chess_pkg::square_t                  square;
   logic [chess_pkg::board_squares-1:0] pawn_map_c;
   logic [chess_pkg::board_cols-1:0]    col_occ_c;
   logic [chess_pkg::board_squares-1:0] pawn_map_t1;
   logic [chess_pkg::board_cols-1:0]    col_occ_t1;

   logic [chess_pkg::board_squares-1:0] isolated_c;
   logic [chess_pkg::board_squares-1:0] connected_c;
   logic [chess_pkg::board_squares-1:0] backward_c;
   logic [2:0]                          distance_c [chess_pkg::board_squares];
   logic [chess_pkg::board_squares-1:0] isolated_t2;
   logic [chess_pkg::board_squares-1:0] connected_t2;
   logic [chess_pkg::board_squares-1:0] backward_t2;
   logic [2:0]                          distance_t2 [chess_pkg::board_squares];

   // indexed term, mg or eg, lane
   logic signed [eval_pkg::eval_width-1:0]
      term_t3 [eval_pkg::term_count][2][chess_pkg::board_squares];
   logic signed [eval_pkg::eval_width-1:0] term_t4 [eval_pkg::term_count][2][16];
   logic signed [eval_pkg::eval_width-1:0] term_t5 [eval_pkg::term_count][2][4];
   logic signed [eval_pkg::eval_width-1:0] term_t6 [eval_pkg::term_count][2];
   logic signed [eval_pkg::eval_width-1:0] total_mg;
   logic signed [eval_pkg::eval_width-1:0] total_eg;

   // off-board squares read as empty
   function automatic logic pawn_rel(
      input logic [chess_pkg::board_squares-1:0] map,
      input int                                   s,
      input int                                   drow,
      input int                                   dcol
   );
      int row;
      int col;
      row = s / chess_pkg::board_cols + drow;
      col = s % chess_pkg::board_cols + dcol;
      if (row < 0 || row >= chess_pkg::board_rows || col < 0 || col >= chess_pkg::board_cols)
         return 1'b0;
      return map[6'(row * chess_pkg::board_cols + col)];
   endfunction

   function automatic logic occupied(
      input logic [chess_pkg::board_cols-1:0] occ,
      input int                               col
   );
      if (col < 0 || col >= chess_pkg::board_cols)
         return 1'b0;
      return occ[3'(col)];
   endfunction

   function automatic logic signed [eval_pkg::eval_width-1:0] sum4(
      input logic signed [eval_pkg::eval_width-1:0] a,
      input logic signed [eval_pkg::eval_width-1:0] b,
      input logic signed [eval_pkg::eval_width-1:0] c,
      input logic signed [eval_pkg::eval_width-1:0] d
   );
      return a + b + c + d;
   endfunction

   // stage 1, pawn map and column occupancy
   always_comb
   begin
      pawn_map_c = '0;
      col_occ_c  = '0;
      square     = '0;
      for (int row = 1; row < chess_pkg::board_rows - 1; row++)
      begin
         for (int col = 0; col < chess_pkg::board_cols; col++)
         begin
            square = board_t0[(row * chess_pkg::board_cols + col) * chess_pkg::piece_width
                              +: chess_pkg::piece_width];
            if (square.code == pawn_code)
            begin
               // black mirrored so both sides score as white
               pawn_map_c[(white_pawns ? row : chess_pkg::board_rows - 1 - row)
                          * chess_pkg::board_cols + col] = 1'b1;
               col_occ_c[col] = 1'b1;
            end
         end
      end
   end

   // stage 2, structure flags
   always_comb
   begin
      isolated_c  = '0;
      connected_c = '0;
      backward_c  = '0;
      for (int s = 0; s < chess_pkg::board_squares; s++)
      begin
         distance_c[s] = '0;
         if (pawn_map_t1[s])
         begin
            isolated_c[s] = !occupied(col_occ_t1, s % chess_pkg::board_cols - 1)
                            && !occupied(col_occ_t1, s % chess_pkg::board_cols + 1);
            for (int d = eval_pkg::max_distance; d >= 1; d--)
               if (pawn_rel(pawn_map_t1, s, d, 0))
                  distance_c[s] = 3'(d); // nearest pawn ahead wins
            connected_c[s] = pawn_rel(pawn_map_t1, s, 0, -1) || pawn_rel(pawn_map_t1, s, 0, 1)
                             || pawn_rel(pawn_map_t1, s, -1, -1)
                             || pawn_rel(pawn_map_t1, s, -1, 1);
            // no neighbour beside or behind, not already isolated or doubled
            backward_c[s] = !isolated_c[s] && !connected_c[s] && distance_c[s] == 3'd0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      board_t0     <= board; // sampling edge
      pawn_map_t1  <= pawn_map_c;
      col_occ_t1   <= col_occ_c;
      isolated_t2  <= isolated_c;
      connected_t2 <= connected_c;
      backward_t2  <= backward_c;
      distance_t2  <= distance_c;
   end

   // stage 3 lookups, stages 4 to 6 adder trees
   always_ff @(posedge clk)
   begin
      for (int s = 0; s < chess_pkg::board_squares; s++)
      begin
         term_t3[eval_pkg::term_isolated][0][s] <= isolated_t2[s] ?
            eval_pkg::isolated_mg[s % chess_pkg::board_cols] : '0;
         term_t3[eval_pkg::term_isolated][1][s] <= isolated_t2[s] ?
            eval_pkg::isolated_eg[s % chess_pkg::board_cols] : '0;
         term_t3[eval_pkg::term_doubled][0][s] <= (distance_t2[s] == 3'd0) ? '0 :
            eval_pkg::doubled_mg[s % chess_pkg::board_cols][distance_t2[s] - 3'd1];
         term_t3[eval_pkg::term_doubled][1][s] <= (distance_t2[s] == 3'd0) ? '0 :
            eval_pkg::doubled_eg[s % chess_pkg::board_cols][distance_t2[s] - 3'd1];
         term_t3[eval_pkg::term_connected][0][s] <= connected_t2[s] ?
            eval_pkg::connected_mg[s / chess_pkg::board_cols][s % chess_pkg::board_cols] : '0;
         term_t3[eval_pkg::term_connected][1][s] <= connected_t2[s] ?
            eval_pkg::connected_eg[s / chess_pkg::board_cols][s % chess_pkg::board_cols] : '0;
         term_t3[eval_pkg::term_backward][0][s] <= backward_t2[s] ?
            eval_pkg::backward_mg[s % chess_pkg::board_cols] : '0;
         term_t3[eval_pkg::term_backward][1][s] <= backward_t2[s] ?
            eval_pkg::backward_eg[s % chess_pkg::board_cols] : '0;
      end

      for (int k = 0; k < eval_pkg::term_count; k++)
      begin
         for (int p = 0; p < 2; p++)
         begin
            for (int i = 0; i < 16; i++)
               term_t4[k][p][i] <= sum4(term_t3[k][p][4 * i], term_t3[k][p][4 * i + 1],
                                        term_t3[k][p][4 * i + 2], term_t3[k][p][4 * i + 3]);
            for (int i = 0; i < 4; i++)
               term_t5[k][p][i] <= sum4(term_t4[k][p][4 * i], term_t4[k][p][4 * i + 1],
                                        term_t4[k][p][4 * i + 2], term_t4[k][p][4 * i + 3]);
            term_t6[k][p] <= sum4(term_t5[k][p][0], term_t5[k][p][1],
                                  term_t5[k][p][2], term_t5[k][p][3]);
         end
      end
   end

   always_comb
   begin
      total_mg = sum4(term_t6[0][0], term_t6[1][0], term_t6[2][0], term_t6[3][0]);
      total_eg = sum4(term_t6[0][1], term_t6[1][1], term_t6[2][1], term_t6[3][1]);
   end

   // stage 7
   always_ff @(posedge clk)
   begin
      eval_mg <= white_pawns ? total_mg : -total_mg;
      eval_eg <= white_pawns ? total_eg : -total_eg;
   end

endmodule

/* verilog/latency_counter.sv */
`timescale 1ns/100ps

module latency_counter
#(
   parameter int width = 4
)
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             load,
   input  logic [width-1:0] load_value,
   input  logic             dec,
   output logic             done
);

   logic [width-1:0] count;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         count <= '0;
      else if (load)
         count <= load_value;
      else if (dec && count != '0)
         count <= count - 1'b1; // holds at zero
   end

   // last decrement, the owner acts on this edge
   assign done = dec && (count == width'(1));

endmodule

/* verilog/latency_sm.sv */
`timescale 1ns/100ps

module latency_sm
(
   input  logic clk,
   input  logic arst_n,
   input  logic board_valid,
   input  logic clear_eval,
   output logic eval_valid
);

   logic [1:0] state;
   logic       counting;
   logic       count_done;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         state <= eval_pkg::sm_idle;
      else if (board_valid)
         state <= eval_pkg::sm_busy; // newest board restarts, beats clear_eval
      else
      begin
         case (state)
            eval_pkg::sm_busy:
               if (count_done)
                  state <= eval_pkg::sm_done;
            eval_pkg::sm_done:
               if (clear_eval)
                  state <= eval_pkg::sm_idle;
            default:
               state <= eval_pkg::sm_idle;
         endcase
      end
   end

   assign counting   = (state == eval_pkg::sm_busy);
   assign eval_valid = (state == eval_pkg::sm_done);

   latency_counter
   #(
      .width (eval_pkg::count_width)
   )
   u_count
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .load       (board_valid),
      .load_value (eval_pkg::latency_load),
      .dec        (counting),
      .done       (count_done)
   );

endmodule

/* verilog/pawn_score_sum.sv */
`timescale 1ns/100ps

module pawn_score_sum
(
   input  logic                                   clk,
   input  logic signed [eval_pkg::eval_width-1:0] white_mg,
   input  logic signed [eval_pkg::eval_width-1:0] white_eg,
   input  logic signed [eval_pkg::eval_width-1:0] black_mg,
   input  logic signed [eval_pkg::eval_width-1:0] black_eg,
   output logic signed [eval_pkg::eval_width-1:0] eval_mg,
   output logic signed [eval_pkg::eval_width-1:0] eval_eg
);

   logic signed [eval_pkg::eval_width:0] sum_mg; // one guard bit
   logic signed [eval_pkg::eval_width:0] sum_eg;

   function automatic logic signed [eval_pkg::eval_width-1:0] clamp(
      input logic signed [eval_pkg::eval_width:0] value
   );
      // guard and sign differ on overflow
      if (value[eval_pkg::eval_width] != value[eval_pkg::eval_width-1])
         return value[eval_pkg::eval_width] ? {1'b1, {(eval_pkg::eval_width - 1){1'b0}}}
                                            : {1'b0, {(eval_pkg::eval_width - 1){1'b1}}};
      return value[eval_pkg::eval_width-1:0];
   endfunction

   assign sum_mg = white_mg + black_mg;
   assign sum_eg = white_eg + black_eg;

   always_ff @(posedge clk)
   begin
      eval_mg <= clamp(sum_mg);
      eval_eg <= clamp(sum_eg);
   end

endmodule

/* verilog/pawn_eval_top.sv */
`timescale 1ns/100ps

module pawn_eval_top
(
   input  logic                                   clk,
   input  logic                                   arst_n,
   input  logic                                   board_valid,
   input  logic [chess_pkg::board_width-1:0]      board,
   input  logic                                   clear_eval,
   output logic signed [eval_pkg::eval_width-1:0] eval_mg,
   output logic signed [eval_pkg::eval_width-1:0] eval_eg,
   output logic                                   eval_valid
);

   logic signed [eval_pkg::eval_width-1:0] white_mg;
   logic signed [eval_pkg::eval_width-1:0] white_eg;
   logic signed [eval_pkg::eval_width-1:0] black_mg; // already negated
   logic signed [eval_pkg::eval_width-1:0] black_eg;

   evaluate_pawns #(.white_pawns(1'b1)) u_white
   (
      .clk     (clk),
      .board   (board),
      .eval_mg (white_mg),
      .eval_eg (white_eg)
   );

   evaluate_pawns #(.white_pawns(1'b0)) u_black
   (
      .clk     (clk),
      .board   (board),
      .eval_mg (black_mg),
      .eval_eg (black_eg)
   );

   pawn_score_sum u_sum
   (
      .clk      (clk),
      .white_mg (white_mg),
      .white_eg (white_eg),
      .black_mg (black_mg),
      .black_eg (black_eg),
      .eval_mg  (eval_mg),
      .eval_eg  (eval_eg)
   );

   latency_sm u_sm
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval_valid  (eval_valid)
   );

endmodule

/* tb/pawn_eval_assert.sv */
`timescale 1ns/100ps

module pawn_eval_assert
(
   input logic                                   clk,
   input logic                                   arst_n,
   input logic                                   board_valid,
   input logic [chess_pkg::board_width-1:0]      board,
   input logic                                   clear_eval,
   input logic signed [eval_pkg::eval_width-1:0] eval_mg,
   input logic signed [eval_pkg::eval_width-1:0] eval_eg,
   input logic                                   eval_valid
);

   logic [chess_pkg::board_width-1:0]      board_q;
   logic [chess_pkg::board_width-1:0]      history [8]; // history[7] matches the outputs
   logic [3:0]                             fill;
   logic [3:0]                             since_board;
   logic signed [eval_pkg::eval_width-1:0] exp_mg;
   logic signed [eval_pkg::eval_width-1:0] exp_eg;
   int                                     fail_count = 0;

   function automatic logic pawn_at(
      input logic [chess_pkg::board_squares-1:0] map,
      input int                                  row,
      input int                                  col
   );
      if (row < 0 || row > 7 || col < 0 || col > 7)
         return 1'b0;
      return map[6'(row * chess_pkg::board_cols + col)];
   endfunction

   // one side's terms as seen from that side
   function automatic int side_score(
      input logic [chess_pkg::board_width-1:0] b,
      input logic                              color,
      input bit                                mg
   );
      chess_pkg::square_t                  sq;
      logic [chess_pkg::board_squares-1:0] own;
      int                                  total;
      int                                  ahead;
      logic                                iso;
      logic                                conn;
      own   = '0;
      total = 0;
      for (int r = 1; r < 7; r++)
         for (int c = 0; c < 8; c++)
         begin
            sq.code = b[(r * 8 + c) * chess_pkg::piece_width +: chess_pkg::piece_width];
            if (sq.fields.kind == chess_pkg::kind_pawn && sq.fields.color == color)
               own[6'((color == chess_pkg::color_white ? r : 7 - r) * 8 + c)] = 1'b1;
         end
      for (int r = 0; r < 8; r++)
         for (int c = 0; c < 8; c++)
            if (pawn_at(own, r, c))
            begin
               iso = 1'b1;
               for (int k = 0; k < 8; k++)
                  if (pawn_at(own, k, c - 1) || pawn_at(own, k, c + 1))
                     iso = 1'b0;
               ahead = 0;
               for (int d = eval_pkg::max_distance; d > 0; d--)
                  if (pawn_at(own, r + d, c))
                     ahead = d; // closest one
               conn = pawn_at(own, r, c - 1) || pawn_at(own, r, c + 1)
                      || pawn_at(own, r - 1, c - 1) || pawn_at(own, r - 1, c + 1);
               if (iso)
                  total += mg ? eval_pkg::isolated_mg[c] : eval_pkg::isolated_eg[c];
               if (ahead > 0)
                  total += mg ? eval_pkg::doubled_mg[c][ahead - 1]
                              : eval_pkg::doubled_eg[c][ahead - 1];
               if (conn)
                  total += mg ? eval_pkg::connected_mg[r][c] : eval_pkg::connected_eg[r][c];
               if (!iso && !conn && ahead == 0)
                  total += mg ? eval_pkg::backward_mg[c] : eval_pkg::backward_eg[c];
            end
      return total;
   endfunction

   function automatic logic signed [eval_pkg::eval_width-1:0] expected_score(
      input logic [chess_pkg::board_width-1:0] b,
      input bit                                mg
   );
      int total;
      int limit;
      limit = 2 ** (eval_pkg::eval_width - 1);
      total = side_score(b, chess_pkg::color_white, mg) - side_score(b, chess_pkg::color_black, mg);
      if (total > limit - 1)
         total = limit - 1;
      else if (total < -limit)
         total = -limit;
      return eval_pkg::eval_width'(total);
   endfunction

   always_ff @(posedge clk)
   begin
      board_q    <= board;
      history[0] <= board_q;
      for (int i = 1; i < 8; i++)
         history[i] <= history[i - 1];
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         fill        <= '0;
         since_board <= '0;
      end
      else
      begin
         if (fill != 4'd9)
            fill <= fill + 4'd1;
         if (board_valid)
            since_board <= 4'd1;
         else if (since_board != 4'd0 && since_board != 4'd15)
            since_board <= since_board + 4'd1; // saturates
      end
   end

   always_comb
   begin
      exp_mg = expected_score(history[7], 1'b1);
      exp_eg = expected_score(history[7], 1'b0);
   end

   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
      since_board == 4'd9 |-> eval_valid)
      else
      begin
         fail_count++;
         $error("eval_valid not high 8 cycles after board_valid");
      end

   a_early: assert property (@(posedge clk) disable iff (!arst_n)
      eval_valid |-> since_board >= 4'd9)
      else
      begin
         fail_count++;
         $error("eval_valid high before the pipeline latency");
      end

   a_clear: assert property (@(posedge clk) disable iff (!arst_n)
      eval_valid && clear_eval && !board_valid |=> !eval_valid)
      else
      begin
         fail_count++;
         $error("eval_valid still high after clear_eval");
      end

   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
      eval_valid && !clear_eval && !board_valid |=> eval_valid)
      else
      begin
         fail_count++;
         $error("eval_valid dropped without clear_eval");
      end

   a_mg: assert property (@(posedge clk) disable iff (!arst_n)
      fill == 4'd9 |-> eval_mg == exp_mg)
      else
      begin
         fail_count++;
         $error("Mismatch eval_mg: got %h, expected %h", $sampled(eval_mg), $sampled(exp_mg));
      end

   a_eg: assert property (@(posedge clk) disable iff (!arst_n)
      fill == 4'd9 |-> eval_eg == exp_eg)
      else
      begin
         fail_count++;
         $error("Mismatch eval_eg: got %h, expected %h", $sampled(eval_eg), $sampled(exp_eg));
      end

endmodule

bind pawn_eval_top pawn_eval_assert u_check
(
   .clk         (clk),
   .arst_n      (arst_n),
   .board_valid (board_valid),
   .board       (board),
   .clear_eval  (clear_eval),
   .eval_mg     (eval_mg),
   .eval_eg     (eval_eg),
   .eval_valid  (eval_valid)
);

/* tb/pawn_eval_tb.sv */
`timescale 1ns/100ps

module pawn_eval_tb;

   localparam int reset_cycles = 16;
   localparam int board_count  = 240;
   localparam int cycle_limit  = 20 * board_count + reset_cycles;

   logic                                   clk = 1'b0;
   logic                                   arst_n;
   logic                                   board_valid;
   logic [chess_pkg::board_width-1:0]      board;
   logic [chess_pkg::board_width-1:0]      next_board;
   logic                                   clear_eval;
   logic signed [eval_pkg::eval_width-1:0] eval_mg;
   logic signed [eval_pkg::eval_width-1:0] eval_eg;
   logic                                   eval_valid;
   int                                     seed     = 32'hd0f9;
   int                                     cycles   = 0;
   int                                     timeouts = 0;

   pawn_eval_top dut
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .board_valid (board_valid),
      .board       (board),
      .clear_eval  (clear_eval),
      .eval_mg     (eval_mg),
      .eval_eg     (eval_eg),
      .eval_valid  (eval_valid)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("Run stopped at the cycle limit of %0d", cycle_limit);
         $display("%0d assertion failures, %0d timeouts", dut.u_check.fail_count, timeouts + 1);
         $display("Testbench failed");
         $finish;
      end
   end

   // all tasks start and end 1 ns after a rising edge
   task automatic put(input int row, input int col, input logic [3:0] code);
      next_board[(row * 8 + col) * chess_pkg::piece_width +: chess_pkg::piece_width] = code;
   endtask

   task automatic random_board;
      int v;
      next_board = '0;
      for (int s = 0; s < chess_pkg::board_squares; s++)
      begin
         v = $random(seed) & 15;
         if (v < 6 && s >= 8 && s < 56) // pawns on rows 1 to 6 only
            put(s / 8, s % 8, v < 3 ? chess_pkg::white_pawn : chess_pkg::black_pawn);
         else if (v < 9)
            put(s / 8, s % 8, {v[0], 3'(2 + v % 5)});
      end
   endtask

   task automatic send_board;
      board       = next_board;
      board_valid = 1'b1;
      @(posedge clk);
      #1;
      board_valid = 1'b0;
   endtask

   task automatic wait_valid;
      int waited;
      waited = 0;
      while (!eval_valid && waited < 20)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (!eval_valid)
      begin
         timeouts++;
         $display("eval_valid did not rise within 20 cycles of board_valid");
      end
   endtask

   task automatic clear_result;
      @(posedge clk);
      #1;
      clear_eval = 1'b1;
      @(posedge clk);
      #1;
      clear_eval = 1'b0;
   endtask

   task automatic evaluate;
      send_board();
      wait_valid();
      clear_result();
   endtask

   initial
   begin
      arst_n      = 1'b0;
      board_valid = 1'b0;
      clear_eval  = 1'b0;
      board       = '0;
      next_board  = '0;
      repeat (reset_cycles) @(posedge clk);
      #1 arst_n = 1'b1;
      repeat (12) @(posedge clk); // nothing offered yet
      #1;
      evaluate();
      for (int c = 0; c < 8; c++)
      begin
         put(0, c, {1'b0, 3'd4});
         put(7, c, {1'b1, 3'd4});
         put(2, c, {c[0], 3'd3});
      end
      evaluate();
      for (int c = 0; c < 16; c++)
      begin
         next_board = '0;
         if (c < 8)
            put(3, c, chess_pkg::white_pawn);
         else
            put(4, c - 8, chess_pkg::black_pawn); // mirror of the white square
         evaluate();
      end
      next_board = '0;
      for (int c = 0; c < 8; c += 2)
      begin
         put(1 + c / 2, c, chess_pkg::white_pawn);
         put(6 - c / 2, c, chess_pkg::black_pawn);
      end
      evaluate();
      next_board = '0;
      put(1, 2, chess_pkg::white_pawn);
      put(3, 2, chess_pkg::white_pawn);
      put(6, 2, chess_pkg::white_pawn);
      put(5, 5, chess_pkg::black_pawn);
      put(2, 5, chess_pkg::black_pawn);
      evaluate();
      next_board = '0;
      put(2, 3, chess_pkg::white_pawn);
      put(2, 4, chess_pkg::white_pawn);
      put(3, 5, chess_pkg::white_pawn);
      put(5, 1, chess_pkg::black_pawn);
      put(4, 2, chess_pkg::black_pawn);
      evaluate();
      next_board = '0;
      put(1, 0, chess_pkg::white_pawn);
      put(3, 1, chess_pkg::white_pawn);
      put(6, 6, chess_pkg::black_pawn);
      put(4, 7, chess_pkg::black_pawn);
      evaluate();
      repeat (200)
      begin
         random_board();
         evaluate();
      end
      // newer board while busy
      random_board();
      send_board();
      repeat (3) @(posedge clk);
      #1;
      random_board();
      evaluate();
      for (int i = 0; i < 16; i++)
      begin
         random_board();
         board       = next_board;
         board_valid = 1'b1;
         @(posedge clk);
         #1;
      end
      board_valid = 1'b0;
      wait_valid();
      clear_result();
      $display("%0d assertion failures, %0d timeouts", dut.u_check.fail_count, timeouts);
      if (dut.u_check.fail_count == 0 && timeouts == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

/* pawn_eval.f */
common/chess_pkg.sv
common/eval_pkg.sv
evaluate_pawns/evaluate_pawns.sv
verilog/latency_counter.sv
verilog/latency_sm.sv
verilog/pawn_score_sum.sv
verilog/pawn_eval_top.sv
tb/pawn_eval_assert.sv
tb/pawn_eval_tb.sv

/* Makefile */
SRC = $(wildcard common/*.sv evaluate_pawns/*.sv verilog/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/Vpawn_eval_tb
	obj_dir/Vpawn_eval_tb +verilator+error+limit+1000 > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Testbench failed" sim.log

obj_dir/Vpawn_eval_tb: pawn_eval.f $(SRC)
	verilator --binary --timing --assert -Wno-fatal --top-module pawn_eval_tb \
		-f pawn_eval.f -o Vpawn_eval_tb

clean:
	rm -rf obj_dir sim.log
